//--- list.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/fpu_unpack_align.sv
verilog/fpu_fract_core.sv
verilog/fpu_norm_round.sv
verilog/fpu_top.sv
tests/fpu_assertions.sv
tests/fpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the FPU testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module fpu_tb -o fpu_sim \
    && ./obj_dir/fpu_sim \
    || { echo "simulation did not complete successfully"; exit 1; }

//--- tests/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

    localparam int CYCLE_LIMIT = 40000;  // ~330 ops at under 100 cycles each, plus margin
    localparam int RANDOM_OPS  = 150;
    localparam int MIXED_OPS   = 20;

    logic              clk;
    logic              reset;
    logic              start;
    fpu_pkg::fpu_op_t  op;
    fpu_pkg::word_t    a;
    fpu_pkg::word_t    b;
    fpu_pkg::word_t    result;
    logic              done;
    int                cycle_count;

    fpu_top dut (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $fatal(1, "cycle limit reached");
    end

    // binary32 to double, zero exponent field reads as zero
    function automatic real word_to_real(input fpu_pkg::word_t w);
        logic [63:0] bits;
        if (w[30:23] == 8'd0) begin
            return 0.0;
        end
        bits = {w[31], {3'b000, w[30:23]} + 11'd896, w[22:0], 29'd0};
        return $bitstoreal(bits);
    endfunction

    // double to binary32, nearest even on the 29 dropped bits
    function automatic fpu_pkg::word_t real_to_word(input real r);
        logic [63:0] bits;
        logic [11:0] exp32;
        logic [24:0] mant;
        logic [28:0] rest;
        if (r == 0.0) begin
            return '0;  // covers -0.0 too
        end
        bits  = $realtobits(r);
        exp32 = {1'b0, bits[62:52]} - 12'd896;
        mant  = {2'b01, bits[51:29]};
        rest  = bits[28:0];
        if (rest > 29'h1000_0000 || (rest == 29'h1000_0000 && mant[0])) begin
            mant = mant + 25'd1;
        end
        if (mant[24]) begin
            mant  = mant >> 1;
            exp32 = exp32 + 12'd1;
        end
        return {bits[63], exp32[7:0], mant[22:0]};
    endfunction

    function automatic fpu_pkg::word_t ref_result(input fpu_pkg::fpu_op_t op_in,
                                                  input fpu_pkg::word_t a_in,
                                                  input fpu_pkg::word_t b_in);
        real ra;
        real rb;
        ra = word_to_real(a_in);
        rb = word_to_real(b_in);
        if (op_in == fpu_pkg::OP_MUL) begin
            return real_to_word(ra * rb);  // 48-bit product, exact in a double
        end
        return real_to_word(ra + rb);
    endfunction

    function automatic fpu_pkg::word_t random_operand(input int exp_lo, input int exp_hi);
        logic [7:0]  exp_field;
        logic [22:0] frac;
        logic        sign;
        sign      = 1'($urandom_range(1, 0));
        exp_field = 8'($urandom_range(exp_hi, exp_lo));
        frac      = 23'($urandom);
        return {sign, exp_field, frac};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_equal(input string name, input fpu_pkg::word_t got,
                               input fpu_pkg::word_t expected);
        assert (got == expected) else begin
            $display("mismatch at %0t ns: %s got %08h expected %08h",
                     $time, name, got, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // one full handshake, start held a random few cycles after done
    task automatic run_op(input fpu_pkg::fpu_op_t op_in, input fpu_pkg::word_t a_in,
                          input fpu_pkg::word_t b_in, input fpu_pkg::word_t expected);
        int hold;
        op    = op_in;
        a     = a_in;
        b     = b_in;
        start = 1'b1;
        next_cycle();
        while (!done) begin
            next_cycle();
        end
        check_equal("result", result, expected);
        hold = int'($urandom_range(5, 0));
        repeat (hold) begin
            next_cycle();
            check_true(done, "done dropped while start was still high");
            check_equal("result", result, expected);
        end
        start = 1'b0;
        next_cycle();
        check_true(!done, "done did not fall one cycle after start went low");
    endtask

    task automatic run_directed(input fpu_pkg::fpu_op_t op_in, input fpu_pkg::word_t a_in,
                                input fpu_pkg::word_t b_in, input fpu_pkg::word_t expected);
        check_true(ref_result(op_in, a_in, b_in) == expected,
                   "reference model disagrees with a directed value");
        run_op(op_in, a_in, b_in, expected);
    endtask

    task automatic run_random(input fpu_pkg::fpu_op_t op_in);
        fpu_pkg::word_t ra;
        fpu_pkg::word_t rb;
        int             ea;
        ra = random_operand(64, 190);
        ea = int'(ra[30:23]);
        if (op_in == fpu_pkg::OP_MUL) begin
            rb = random_operand(64, 190);
        end else begin
            // exponents within 20 keep the double sum exact
            rb = random_operand((ea - 20 < 64) ? 64 : ea - 20, (ea + 20 > 190) ? 190 : ea + 20);
        end
        run_op(op_in, ra, rb, ref_result(op_in, ra, rb));
    endtask

    initial begin
        fpu_pkg::fpu_op_t mix_op;
        void'($urandom(52476));
        reset = 1'b1;
        start = 1'b0;
        op    = fpu_pkg::OP_ADD;
        a     = '0;
        b     = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (3) begin  // idle after reset
            check_true(!done, "done is high before any start");
            check_equal("result", result, 32'h0000_0000);
            next_cycle();
        end

        run_directed(fpu_pkg::OP_ADD, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000);
        run_directed(fpu_pkg::OP_ADD, 32'h40A0_0000, 32'hC040_0000, 32'h4000_0000);
        run_directed(fpu_pkg::OP_ADD, 32'h3F9D_F3B6, 32'hBF9D_F3B6, 32'h0000_0000);
        run_directed(fpu_pkg::OP_ADD, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000);  // tie, even
        run_directed(fpu_pkg::OP_ADD, 32'h3F80_0000, 32'h3440_0000, 32'h3F80_0002);  // tie, odd

        run_directed(fpu_pkg::OP_MUL, 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000);
        run_directed(fpu_pkg::OP_MUL, 32'hC020_0000, 32'h4080_0000, 32'hC120_0000);
        run_directed(fpu_pkg::OP_MUL, 32'h0012_3456, 32'h4040_0000, 32'h0000_0000);
        run_directed(fpu_pkg::OP_MUL, 32'hC000_0000, 32'h8000_0000, 32'h0000_0000);
        run_directed(fpu_pkg::OP_MUL, 32'h3FE0_0000, 32'h3FE0_0000, 32'h4044_0000);  // 1.75 squared

        repeat (RANDOM_OPS) begin
            run_random(fpu_pkg::OP_ADD);
        end
        repeat (RANDOM_OPS) begin
            run_random(fpu_pkg::OP_MUL);
        end

        repeat (MIXED_OPS) begin
            mix_op = ($urandom_range(1, 0) == 1) ? fpu_pkg::OP_MUL : fpu_pkg::OP_ADD;
            run_random(mix_op);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/fpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_assertions (
    input wire                 clk,
    input wire                 reset,
    input wire                 start,
    input wire                 done,
    input wire fpu_pkg::word_t result
);

    // reset clears the handshake
    done_low_after_reset: assert property (
        @(posedge clk) reset |=> !done
    ) else $error("done is high in the cycle after reset");

    // environment holds the result by keeping start high
    done_held_with_start: assert property (
        @(posedge clk) disable iff (reset)
        done && start |=> done
    ) else $error("done fell while start was still high");

    result_stable_with_done: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done || $stable(result)  // no change while the result is offered
    ) else $error("result changed while done was high");

endmodule

bind fpu_top fpu_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .done   (done),
    .result (result)
);

`default_nettype wire

//--- verilog/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_config.svh"

module fpu_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire fpu_pkg::fpu_op_t   op,
    input  wire fpu_pkg::word_t     a,
    input  wire fpu_pkg::word_t     b,
    output wire fpu_pkg::word_t     result,
    output wire                     done
);

    wire                     align_valid;
    wire                     is_mul;
    wire                     big_sign;
    wire                     small_sign;
    wire fpu_pkg::wide_exp_t exponent;
    wire fpu_pkg::work_t     big_work;
    wire fpu_pkg::work_t     small_work;
    wire fpu_pkg::mant_t     mant_a;
    wire fpu_pkg::mant_t     mant_b;

    wire                     core_valid;
    wire fpu_pkg::work_t     core_work;
    wire fpu_pkg::wide_exp_t core_exp;
    wire                     core_sign;

    wire                     release_pulse;  // back to the input side when done falls

    fpu_unpack_align u_unpack_align (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .op            (op),
        .a             (a),
        .b             (b),
        .release_pulse (release_pulse),
        .align_valid   (align_valid),
        .is_mul        (is_mul),
        .big_sign      (big_sign),
        .small_sign    (small_sign),
        .exponent      (exponent),
        .big_work      (big_work),
        .small_work    (small_work),
        .mant_a        (mant_a),
        .mant_b        (mant_b)
    );

    fpu_fract_core u_fract_core (
        .clk         (clk),
        .reset       (reset),
        .align_valid (align_valid),
        .is_mul      (is_mul),
        .big_sign    (big_sign),
        .small_sign  (small_sign),
        .exponent    (exponent),
        .big_work    (big_work),
        .small_work  (small_work),
        .mant_a      (mant_a),
        .mant_b      (mant_b),
        .core_valid  (core_valid),
        .core_work   (core_work),
        .core_exp    (core_exp),
        .core_sign   (core_sign)
    );

    fpu_norm_round u_norm_round (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .core_valid    (core_valid),
        .core_work     (core_work),
        .core_exp      (core_exp),
        .core_sign     (core_sign),
        .result        (result),
        .done          (done),
        .release_pulse (release_pulse)
    );

endmodule

`default_nettype wire

//--- verilog/fpu_norm_round.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_config.svh"

module fpu_norm_round (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire                        core_valid,
    input  wire fpu_pkg::work_t        core_work,
    input  wire fpu_pkg::wide_exp_t    core_exp,
    input  wire                        core_sign,
    output fpu_pkg::word_t             result,
    output logic                       done,
    output logic                       release_pulse
);

    fpu_pkg::norm_state_t state;
    fpu_pkg::work_t       work_q;
    fpu_pkg::wide_exp_t   exp_q;
    logic                 sign_q;
    logic                 zero_q;
    logic                 round_up;
    logic [`FPU_WORK_W-4:0] rounded;  // carry plus mantissa

    // nearest even, a tie only rounds up onto an odd lsb
    assign round_up = work_q[`FPU_GUARD_BIT] & (work_q[`FPU_ROUND_BIT]
                    | work_q[`FPU_STICKY_BIT] | work_q[`FPU_LSB_BIT]);
    assign rounded  = work_q[`FPU_CARRY_BIT:`FPU_LSB_BIT] + {{(`FPU_WORK_W-4){1'b0}}, round_up};

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= fpu_pkg::NORM_IDLE;
            done          <= 1'b0;
            release_pulse <= 1'b0;
            result        <= '0;
        end else begin
            release_pulse <= 1'b0;
            case (state)
                fpu_pkg::NORM_IDLE: begin
                    if (core_valid) begin
                        if (core_work == '0) begin
                            state <= fpu_pkg::NORM_PACK;
                        end else if (core_work[`FPU_CARRY_BIT]
                                     || !core_work[`FPU_HIDDEN_BIT]) begin
                            state <= fpu_pkg::NORM_SHIFT;
                        end else begin
                            state <= fpu_pkg::NORM_ROUND;
                        end
                    end
                end
                fpu_pkg::NORM_SHIFT: begin
                    if (work_q[`FPU_CARRY_BIT] || work_q[`FPU_HIDDEN_BIT-1]) begin
                        state <= fpu_pkg::NORM_ROUND;
                    end
                end
                fpu_pkg::NORM_ROUND: begin
                    state <= rounded[`FPU_WORK_W-4] ? fpu_pkg::NORM_RENORM : fpu_pkg::NORM_PACK;
                end
                fpu_pkg::NORM_RENORM: begin
                    state <= fpu_pkg::NORM_PACK;
                end
                fpu_pkg::NORM_PACK: begin
                    result <= zero_q ? '0 : {sign_q, exp_q[`FPU_EXP_W-1:0],
                                             work_q[`FPU_HIDDEN_BIT-1:`FPU_LSB_BIT]};
                    done   <= 1'b1;
                    state  <= fpu_pkg::NORM_HOLD;
                end
                fpu_pkg::NORM_HOLD: begin
                    if (!start) begin  // environment has taken the result
                        done          <= 1'b0;
                        release_pulse <= 1'b1;
                        state         <= fpu_pkg::NORM_IDLE;
                    end
                end
                default: state <= fpu_pkg::NORM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            fpu_pkg::NORM_IDLE: begin
                if (core_valid) begin
                    work_q <= core_work;
                    exp_q  <= core_exp;
                    sign_q <= core_sign;
                    zero_q <= (core_work == '0);  // exact zero packs as +0
                end
            end
            fpu_pkg::NORM_SHIFT: begin
                if (work_q[`FPU_CARRY_BIT]) begin
                    work_q <= {1'b0, work_q[`FPU_CARRY_BIT:2], work_q[1] | work_q[0]};
                    exp_q  <= exp_q + 10'sd1;
                end else begin
                    work_q <= work_q << 1;  // one bit per cycle after cancellation
                    exp_q  <= exp_q - 10'sd1;
                end
            end
            fpu_pkg::NORM_ROUND: begin
                work_q <= {rounded, 3'b000};
            end
            fpu_pkg::NORM_RENORM: begin
                work_q <= work_q >> 1;  // rounding carried out, low bits already zero
                exp_q  <= exp_q + 10'sd1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fpu_fract_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_config.svh"

module fpu_fract_core (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        align_valid,
    input  wire                        is_mul,
    input  wire                        big_sign,
    input  wire                        small_sign,
    input  wire fpu_pkg::wide_exp_t    exponent,
    input  wire fpu_pkg::work_t        big_work,
    input  wire fpu_pkg::work_t        small_work,
    input  wire fpu_pkg::mant_t        mant_a,
    input  wire fpu_pkg::mant_t        mant_b,
    output logic                       core_valid,
    output fpu_pkg::work_t             core_work,
    output fpu_pkg::wide_exp_t         core_exp,
    output logic                       core_sign
);

    fpu_pkg::core_state_t state;
    logic [4:0]           step_cnt;
    fpu_pkg::prod_t       mcand;     // shifts left each step
    fpu_pkg::mant_t       mplier;    // shifts right each step
    fpu_pkg::prod_t       acc;
    fpu_pkg::work_t       add_work;

    // magnitudes are ordered, so the difference never goes negative
    assign add_work = (big_sign == small_sign) ? big_work + small_work
                                               : big_work - small_work;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= fpu_pkg::CORE_IDLE;
            core_valid <= 1'b0;
        end else begin
            core_valid <= 1'b0;
            case (state)
                fpu_pkg::CORE_IDLE: begin
                    if (align_valid) begin
                        if (is_mul) begin
                            state <= fpu_pkg::CORE_MUL;
                        end else begin
                            core_valid <= 1'b1;  // add finishes here
                        end
                    end
                end
                fpu_pkg::CORE_MUL: begin
                    if (step_cnt == 5'(`FPU_MUL_STEPS - 1)) begin
                        state <= fpu_pkg::CORE_REDUCE;
                    end
                end
                fpu_pkg::CORE_REDUCE: begin
                    core_valid <= 1'b1;
                    state      <= fpu_pkg::CORE_IDLE;
                end
                default: state <= fpu_pkg::CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            fpu_pkg::CORE_IDLE: begin
                if (align_valid) begin
                    core_exp <= exponent;
                    step_cnt <= '0;
                    mcand    <= {{`FPU_MANT_W{1'b0}}, mant_a};
                    mplier   <= mant_b;
                    acc      <= '0;
                    if (is_mul) begin
                        core_sign <= big_sign ^ small_sign;
                    end else begin
                        core_sign <= big_sign;
                        core_work <= add_work;
                    end
                end
            end
            fpu_pkg::CORE_MUL: begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                mcand    <= mcand << 1;
                mplier   <= mplier >> 1;
                step_cnt <= step_cnt + 5'd1;
            end
            fpu_pkg::CORE_REDUCE: begin
                // binary point sits below bit 46, a zero mantissa leaves acc at zero
                core_work <= {acc[47], acc[46:23], acc[22], acc[21], |acc[20:0]};
            end
            default: begin
                step_cnt <= '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fpu_unpack_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpu_config.svh"

module fpu_unpack_align (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire fpu_pkg::fpu_op_t      op,
    input  wire fpu_pkg::word_t        a,
    input  wire fpu_pkg::word_t        b,
    input  wire                        release_pulse,
    output logic                       align_valid,
    output logic                       is_mul,
    output logic                       big_sign,
    output logic                       small_sign,
    output fpu_pkg::wide_exp_t         exponent,
    output fpu_pkg::work_t             big_work,
    output fpu_pkg::work_t             small_work,
    output fpu_pkg::mant_t             mant_a,
    output fpu_pkg::mant_t             mant_b
);

    fpu_pkg::align_state_t state;
    fpu_pkg::fpu_op_t      op_q;
    fpu_pkg::word_t        a_q;
    fpu_pkg::word_t        b_q;

    fpu_pkg::exp_t         exp_a;
    fpu_pkg::exp_t         exp_b;
    fpu_pkg::mant_t        man_a;
    fpu_pkg::mant_t        man_b;
    logic                  a_ge_b;
    fpu_pkg::exp_t         big_exp;
    fpu_pkg::exp_t         small_exp;
    fpu_pkg::exp_t         exp_diff;
    fpu_pkg::mant_t        big_mant;
    fpu_pkg::mant_t        small_mant;
    fpu_pkg::work_t        small_base;
    fpu_pkg::work_t        small_shift;
    fpu_pkg::work_t        lost_mask;
    logic                  sticky;
    fpu_pkg::wide_exp_t    mul_exp;

    assign exp_a = a_q[`FPU_EXP_W+`FPU_FRAC_W-1:`FPU_FRAC_W];
    assign exp_b = b_q[`FPU_EXP_W+`FPU_FRAC_W-1:`FPU_FRAC_W];

    // zero exponent field means zero, fraction ignored
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a_q[`FPU_FRAC_W-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b_q[`FPU_FRAC_W-1:0]};

    assign a_ge_b     = {exp_a, man_a} >= {exp_b, man_b};  // magnitude order
    assign big_exp    = a_ge_b ? exp_a : exp_b;
    assign small_exp  = a_ge_b ? exp_b : exp_a;
    assign big_mant   = a_ge_b ? man_a : man_b;
    assign small_mant = a_ge_b ? man_b : man_a;
    assign exp_diff   = big_exp - small_exp;

    assign mul_exp = fpu_pkg::wide_exp_t'(exp_a) + fpu_pkg::wide_exp_t'(exp_b)
                   - fpu_pkg::wide_exp_t'(`FPU_BIAS);

    // align the smaller fraction, bits falling off the end fold into sticky
    always_comb begin
        small_base = {1'b0, small_mant, 3'b000};
        lost_mask  = '1;
        if (int'(exp_diff) >= `FPU_WORK_W) begin
            small_shift = '0;
            sticky      = |small_base;
        end else begin
            small_shift = small_base >> exp_diff;
            lost_mask   = ~({`FPU_WORK_W{1'b1}} << exp_diff);
            sticky      = |(small_base & lost_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= fpu_pkg::ALIGN_IDLE;
            align_valid <= 1'b0;
        end else begin
            align_valid <= 1'b0;
            case (state)
                fpu_pkg::ALIGN_IDLE: begin
                    if (start) begin
                        state <= fpu_pkg::ALIGN_ALIGN;
                    end
                end
                fpu_pkg::ALIGN_ALIGN: begin
                    align_valid <= 1'b1;
                    state       <= fpu_pkg::ALIGN_BUSY;
                end
                fpu_pkg::ALIGN_BUSY: begin
                    if (release_pulse) begin  // start ignored until here
                        state <= fpu_pkg::ALIGN_IDLE;
                    end
                end
                default: state <= fpu_pkg::ALIGN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fpu_pkg::ALIGN_IDLE && start) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
        if (state == fpu_pkg::ALIGN_ALIGN) begin
            is_mul     <= (op_q == fpu_pkg::OP_MUL);  // unknown codes add
            big_sign   <= a_ge_b ? a_q[31] : b_q[31];
            small_sign <= a_ge_b ? b_q[31] : a_q[31];
            exponent   <= (op_q == fpu_pkg::OP_MUL) ? mul_exp
                                                    : fpu_pkg::wide_exp_t'(big_exp);
            big_work   <= {1'b0, big_mant, 3'b000};
            small_work <= {small_shift[`FPU_WORK_W-1:1], small_shift[0] | sticky};
            mant_a     <= man_a;
            mant_b     <= man_b;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fpu_pkg.sv
`default_nettype none
`include "fpu_config.svh"

package fpu_pkg;

    typedef logic [`FPU_EXP_W+`FPU_FRAC_W:0] word_t;  // sign, exponent, fraction
    typedef logic [`FPU_EXP_W-1:0]           exp_t;   // biased exponent field
    typedef logic signed [`FPU_EXP_W+1:0]    wide_exp_t;  // headroom for sums and steps
    typedef logic [`FPU_MANT_W-1:0]          mant_t;  // hidden bit included
    typedef logic [`FPU_WORK_W-1:0]          work_t;
    typedef logic [2*`FPU_MANT_W-1:0]        prod_t;  // full 24x24 product

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_MUL = 2'b10
    } fpu_op_t;

    typedef enum logic [1:0] {
        ALIGN_IDLE,
        ALIGN_ALIGN,
        ALIGN_BUSY
    } align_state_t;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_MUL,
        CORE_REDUCE
    } core_state_t;

    typedef enum logic [2:0] {
        NORM_IDLE,
        NORM_SHIFT,
        NORM_ROUND,
        NORM_RENORM,
        NORM_PACK,
        NORM_HOLD
    } norm_state_t;

endpackage

`default_nettype wire

//--- verilog/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// binary32 field layout
`define FPU_EXP_W       8
`define FPU_FRAC_W      23
`define FPU_BIAS        127
`define FPU_MANT_W      24

// work word is carry, hidden bit and fraction, then guard, round, sticky
`define FPU_WORK_W      28
`define FPU_CARRY_BIT   27
`define FPU_HIDDEN_BIT  26
`define FPU_LSB_BIT     3
`define FPU_GUARD_BIT   2
`define FPU_ROUND_BIT   1
`define FPU_STICKY_BIT  0

// one multiplier bit per cycle
`define FPU_MUL_STEPS   24

`endif
